// ==== axi2per.f ====
+incdir+.
axi2per_pkg.sv
axi2per_req_channel.sv
axi2per_res_channel.sv
axi2per.sv
tb_axi2per.sv

// ==== axi2per.sv ====
module axi2per (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // ****************************************
  // AXI slave port
  // ****************************************
  input  logic                   aw_valid_i,
  input  axi2per_pkg::axi_aw_t   aw_i,
  output logic                   aw_ready_o,
  input  logic                   w_valid_i,
  input  axi2per_pkg::axi_w_t    w_i,
  output logic                   w_ready_o,
  input  logic                   ar_valid_i,
  input  axi2per_pkg::axi_ar_t   ar_i,
  output logic                   ar_ready_o,
  output logic                   r_valid_o,
  output axi2per_pkg::axi_r_t    r_o,
  input  logic                   r_ready_i,
  output logic                   b_valid_o,
  output axi2per_pkg::axi_b_t    b_o,
  input  logic                   b_ready_i,

  // ****************************************
  // Peripheral master port
  // ****************************************
  output logic                   per_req_o,
  output axi2per_pkg::per_req_t  per_req_data_o,
  input  logic                   per_gnt_i,
  input  logic                   per_r_valid_i,
  input  axi2per_pkg::per_resp_t per_resp_i
);

  // Links between the two halves
  logic                trans_req;
  axi2per_pkg::trans_t trans;
  logic                trans_done;

  // Accepts AXI requests, drives the peripheral bus
  axi2per_req_channel u_req_channel (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .aw_valid_i     (aw_valid_i),
    .aw_i           (aw_i),
    .aw_ready_o     (aw_ready_o),
    .w_valid_i      (w_valid_i),
    .w_i            (w_i),
    .w_ready_o      (w_ready_o),
    .ar_valid_i     (ar_valid_i),
    .ar_i           (ar_i),
    .ar_ready_o     (ar_ready_o),
    .per_req_o      (per_req_o),
    .per_req_data_o (per_req_data_o),
    .per_gnt_i      (per_gnt_i),
    .trans_req_o    (trans_req),
    .trans_o        (trans),
    .trans_done_i   (trans_done)
  );

  // Returns peripheral responses on R or B
  axi2per_res_channel u_res_channel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .per_r_valid_i (per_r_valid_i),
    .per_resp_i    (per_resp_i),
    .trans_req_i   (trans_req),
    .trans_i       (trans),
    .r_valid_o     (r_valid_o),
    .r_o           (r_o),
    .r_ready_i     (r_ready_i),
    .b_valid_o     (b_valid_o),
    .b_o           (b_o),
    .b_ready_i     (b_ready_i),
    .trans_done_o  (trans_done)
  );

endmodule

// ==== axi2per_pkg.sv ====
`include "axi2per_settings.svh"

package axi2per_pkg;

  // AXI response codes used by the bridge
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ****************************************
  // AXI channel payloads
  // ****************************************

  // Write address, also reused for read address
  typedef struct packed {
    logic [`AXI2PER_AXI_ID_W-1:0]   id;
    logic [`AXI2PER_AXI_ADDR_W-1:0] addr;
    logic [`AXI2PER_AXI_USER_W-1:0] user;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  // Write data with one strobe per byte
  typedef struct packed {
    logic [`AXI2PER_AXI_DATA_W-1:0]   data;
    logic [`AXI2PER_AXI_DATA_W/8-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI2PER_AXI_ID_W-1:0]   id;
    logic [`AXI2PER_AXI_DATA_W-1:0] data;
    logic [1:0]                     resp;
    logic                           last;
    logic [`AXI2PER_AXI_USER_W-1:0] user;
  } axi_r_t;

  typedef struct packed {
    logic [`AXI2PER_AXI_ID_W-1:0]   id;
    logic [1:0]                     resp;
    logic [`AXI2PER_AXI_USER_W-1:0] user;
  } axi_b_t;

  // Two 32-bit halves of one AXI data word
  typedef struct packed {
    logic [`AXI2PER_AXI_DATA_W/2-1:0] hi;
    logic [`AXI2PER_AXI_DATA_W/2-1:0] lo;
  } axi_half_t;

  // Same data word, seen whole or split into lanes
  typedef union packed {
    logic [`AXI2PER_AXI_DATA_W-1:0] word;
    axi_half_t                      half;
  } axi_lane_u;

  // ****************************************
  // Peripheral bus payloads
  // ****************************************

  // wen_n high means read
  typedef struct packed {
    logic [`AXI2PER_PER_ADDR_W-1:0]   add;
    logic                             wen_n;
    logic [`AXI2PER_PER_DATA_W-1:0]   wdata;
    logic [`AXI2PER_PER_DATA_W/8-1:0] be;
  } per_req_t;

  // opc high flags an error
  typedef struct packed {
    logic                           opc;
    logic [`AXI2PER_PER_DATA_W-1:0] rdata;
  } per_resp_t;

  // Record of the transaction in flight, lane is address bit 2
  typedef struct packed {
    logic                           wen_n;
    logic [`AXI2PER_AXI_ID_W-1:0]   id;
    logic [`AXI2PER_AXI_USER_W-1:0] user;
    logic                           lane;
  } trans_t;

endpackage

// ==== axi2per_req_channel.sv ====
module axi2per_req_channel (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // AXI write address and data
  input  logic                  aw_valid_i,
  input  axi2per_pkg::axi_aw_t  aw_i,
  output logic                  aw_ready_o,
  input  logic                  w_valid_i,
  input  axi2per_pkg::axi_w_t   w_i,
  output logic                  w_ready_o,

  // AXI read address
  input  logic                  ar_valid_i,
  input  axi2per_pkg::axi_ar_t  ar_i,
  output logic                  ar_ready_o,

  // Peripheral request
  output logic                  per_req_o,
  output axi2per_pkg::per_req_t per_req_data_o,
  input  logic                  per_gnt_i,

  // Link to the response channel
  output logic                  trans_req_o,
  output axi2per_pkg::trans_t   trans_o,
  input  logic                  trans_done_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } state_e;

  state_e                state_d, state_q;

  axi2per_pkg::axi_lane_u w_lane;
  logic                   idle;
  logic                   ar_take;
  logic                   w_take;
  logic                   w_hi;

  axi2per_pkg::per_req_t  per_req_d, per_req_q;
  axi2per_pkg::trans_t    trans_d, trans_q;

  // ****************************************
  // Acceptance and arbitration
  // ****************************************

  assign idle = (state_q == st_idle);

  // Reads win over writes
  assign ar_take = idle && ar_valid_i;
  // Write needs AW and W together
  assign w_take  = idle && !ar_valid_i && aw_valid_i && w_valid_i;

  // All readies high while idle with nothing pending
  assign ar_ready_o = idle;
  // AW or W alone is held back until its partner shows up
  assign aw_ready_o = idle && !ar_valid_i && (w_valid_i || !aw_valid_i);
  assign w_ready_o  = idle && !ar_valid_i && (aw_valid_i || !w_valid_i);

  // ****************************************
  // Write lane steering
  // ****************************************

  // Split the 64-bit write word into its two halves
  assign w_lane = w_i.data;
  // Address bit 2 picks the upper half
  assign w_hi   = aw_i.addr[2];

  // Next request payload and transaction record
  always_comb begin
    per_req_d = per_req_q;
    trans_d   = trans_q;
    if (ar_take) begin
      per_req_d.add   = ar_i.addr;
      per_req_d.wen_n = 1'b1;
      // No data on a read, all bytes enabled
      per_req_d.wdata = '0;
      per_req_d.be    = '1;
      trans_d.wen_n   = 1'b1;
      trans_d.id      = ar_i.id;
      trans_d.user    = ar_i.user;
      trans_d.lane    = ar_i.addr[2];
    end else if (w_take) begin
      per_req_d.add   = aw_i.addr;
      per_req_d.wen_n = 1'b0;
      // Forward only the selected lane and its strobes
      per_req_d.wdata = w_hi ? w_lane.half.hi : w_lane.half.lo;
      per_req_d.be    = w_hi ? w_i.strb[7:4] : w_i.strb[3:0];
      trans_d.wen_n   = 1'b0;
      trans_d.id      = aw_i.id;
      trans_d.user    = aw_i.user;
      trans_d.lane    = w_hi;
    end
  end

  // ****************************************
  // Control FSM
  // ****************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (ar_take || w_take) begin
          state_d = st_request;
        end
      end
      // Hold the request until granted
      st_request: begin
        if (per_gnt_i) begin
          state_d = st_wait;
        end
      end
      // Busy until the AXI response has been taken
      st_wait: begin
        if (trans_done_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload only changes at acceptance
  always_ff @(posedge clk_i) begin
    per_req_q <= per_req_d;
    trans_q   <= trans_d;
  end

  // Outputs
  assign per_req_o      = (state_q == st_request);
  assign per_req_data_o = per_req_q;
  // Handoff to the response side in the grant cycle
  assign trans_req_o    = per_req_o && per_gnt_i;
  assign trans_o        = trans_q;

endmodule

// ==== axi2per_res_channel.sv ====
module axi2per_res_channel (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Peripheral response
  input  logic                   per_r_valid_i,
  input  axi2per_pkg::per_resp_t per_resp_i,

  // Record from the request channel
  input  logic                   trans_req_i,
  input  axi2per_pkg::trans_t    trans_i,

  // AXI read data
  output logic                   r_valid_o,
  output axi2per_pkg::axi_r_t    r_o,
  input  logic                   r_ready_i,

  // AXI write response
  output logic                   b_valid_o,
  output axi2per_pkg::axi_b_t    b_o,
  input  logic                   b_ready_i,

  // Completion back to the request channel
  output logic                   trans_done_o
);

  typedef enum logic {
    st_idle,
    st_pending
  } state_e;

  state_e                 state_d, state_q;

  axi2per_pkg::trans_t    trans_q;
  axi2per_pkg::per_resp_t resp_q;
  axi2per_pkg::axi_lane_u r_lane;
  logic [1:0]             resp;
  logic                   capture;

  // ****************************************
  // Response capture
  // ****************************************

  // Only one response per grant, taken while idle
  assign capture = (state_q == st_idle) && per_r_valid_i;

  always_ff @(posedge clk_i) begin
    if (trans_req_i) begin
      trans_q <= trans_i;
    end
    if (capture) begin
      resp_q <= per_resp_i;
    end
  end

  // Place read data in the recorded lane, other half stays zero
  always_comb begin
    r_lane = '0;
    if (trans_q.lane) begin
      r_lane.half.hi = resp_q.rdata;
    end else begin
      r_lane.half.lo = resp_q.rdata;
    end
  end

  // Peripheral error maps to SLVERR
  assign resp = resp_q.opc ? axi2per_pkg::RESP_SLVERR : axi2per_pkg::RESP_OKAY;

  // ****************************************
  // AXI response channels
  // ****************************************

  // R or B depending on direction, held until ready
  assign r_valid_o = (state_q == st_pending) && trans_q.wen_n;
  assign b_valid_o = (state_q == st_pending) && !trans_q.wen_n;

  always_comb begin
    r_o.id   = trans_q.id;
    r_o.data = r_lane.word;
    r_o.resp = resp;
    // Single beat, so always last
    r_o.last = 1'b1;
    r_o.user = trans_q.user;
  end

  always_comb begin
    b_o.id   = trans_q.id;
    b_o.resp = resp;
    b_o.user = trans_q.user;
  end

  // Done in the handshake cycle
  assign trans_done_o = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

  // FSM
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (capture) begin
          state_d = st_pending;
        end
      end
      st_pending: begin
        if (trans_done_o) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== axi2per_settings.svh ====
`ifndef AXI2PER_SETTINGS_SVH
`define AXI2PER_SETTINGS_SVH

// ****************************************
// AXI slave port widths
// ****************************************
`define AXI2PER_AXI_ADDR_W 32
`define AXI2PER_AXI_DATA_W 64
`define AXI2PER_AXI_ID_W   3
`define AXI2PER_AXI_USER_W 6

// ****************************************
// Peripheral master port widths
// ****************************************
`define AXI2PER_PER_ADDR_W 32
`define AXI2PER_PER_DATA_W 32

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the axi2per testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f axi2per.f \
  --top-module tb_axi2per -o sim_axi2per > build.log 2>&1 \
  && ./obj_dir/sim_axi2per > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

# Verdict comes from the simulation log
grep -qF '** FAIL **' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "No verdict found in sim.log"; exit 1; }
echo "Simulation passed"

// ==== tb_axi2per.sv ====
module tb_axi2per;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_wait = 100;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   aw_valid_i;
  logic                   aw_ready_o;
  logic                   w_valid_i;
  logic                   w_ready_o;
  logic                   ar_valid_i;
  logic                   ar_ready_o;
  logic                   r_valid_o;
  logic                   r_ready_i;
  logic                   b_valid_o;
  logic                   b_ready_i;
  logic                   per_req_o;
  logic                   per_gnt_i;
  logic                   per_r_valid_i;
  axi2per_pkg::axi_aw_t   aw_i;
  axi2per_pkg::axi_w_t    w_i;
  axi2per_pkg::axi_ar_t   ar_i;
  axi2per_pkg::axi_r_t    r_o;
  axi2per_pkg::axi_b_t    b_o;
  axi2per_pkg::per_req_t  per_req_data_o;
  axi2per_pkg::per_resp_t per_resp_i;

  integer      seed = 76;
  int          error_count;
  int          timeout_count;
  logic        in_flight;
  // Reference copy of memory updated from AXI writes
  logic [31:0] shadow_mem [256];
  // Storage of the peripheral model
  logic [31:0] per_mem [256];

  // Request expected on the peripheral bus
  logic        exp_wen_n;
  logic [31:0] exp_add;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_be;

  axi2per u_axi2per (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ****************************************
  // Helpers
  // ****************************************

  // Initial word contents built from every index bit
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'h5a, idx + 8'h3c, ~idx, idx};
  endfunction

  // Top of the address map answers with SLVERR
  function automatic logic [1:0] expected_resp(input logic [31:0] addr);
    return (addr >= 32'h400) ? 2'b10 : 2'b00;
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error @ %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, max_wait);
  endtask

  // ****************************************
  // Protocol checks
  // ****************************************

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)))
    else report_error("R valid dropped or payload changed before ready");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_o)))
    else report_error("B valid dropped or payload changed before ready");

  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (per_req_o && !per_gnt_i) |=> (per_req_o && $stable(per_req_data_o)))
    else report_error("Peripheral request dropped or changed before grant");

  // A pending read keeps the write side waiting
  read_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i |-> (!aw_ready_o && !w_ready_o))
    else report_error("AW or W ready high while AR is valid");

  // Peripheral request follows acceptance by one cycle
  accept_to_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((ar_valid_i && ar_ready_o) || (aw_valid_i && aw_ready_o && w_valid_i && w_ready_o))
      |=> per_req_o)
    else report_error("per_req_o not high in the cycle after acceptance");

  // Response valid follows the peripheral response by one cycle
  resp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    per_r_valid_i |=> (r_valid_o || b_valid_o))
    else report_error("No R or B valid in the cycle after the peripheral response");

  // Tracks the single transaction and what the peripheral should see
  always @(posedge clk_i) begin : bus_monitor
    logic ar_acc;
    logic w_acc;
    logic done;
    ar_acc = ar_valid_i && ar_ready_o;
    w_acc  = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;
    done   = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);
    if (!rst_ni) begin
      in_flight = 1'b0;
    end else begin
      assert (!(in_flight && (aw_ready_o || w_ready_o || ar_ready_o)))
        else report_error("AXI ready high while a transaction is in flight");
      assert (!per_req_o || in_flight)
        else report_error("per_req_o high with no accepted transaction");
      // R only answers a read, B only answers a write
      assert (!r_valid_o || (in_flight && exp_wen_n))
        else report_error("R valid without a read in flight");
      assert (!b_valid_o || (in_flight && !exp_wen_n))
        else report_error("B valid without a write in flight");
      if (ar_acc) begin
        exp_wen_n = 1'b1;
        exp_add   = ar_i.addr;
      end else if (w_acc) begin
        exp_wen_n = 1'b0;
        exp_add   = aw_i.addr;
        // Address bit 2 picks the lane
        exp_wdata = aw_i.addr[2] ? w_i.data[63:32] : w_i.data[31:0];
        exp_be    = aw_i.addr[2] ? w_i.strb[7:4] : w_i.strb[3:0];
      end
      if (ar_acc || w_acc) begin
        in_flight = 1'b1;
      end
      if (done) begin
        in_flight = 1'b0;
      end
    end
  end

  // ****************************************
  // Peripheral model
  // ****************************************

  initial begin : peripheral_model
    axi2per_pkg::per_req_t  req;
    axi2per_pkg::per_resp_t resp;
    int idx;
    int delay;
    per_gnt_i     = 1'b0;
    per_r_valid_i = 1'b0;
    per_resp_i    = '0;
    for (idx = 0; idx < 256; idx++) begin
      per_mem[idx] = fill_word(idx[7:0]);
    end
    forever begin
      @(posedge clk_i);
      if (per_req_o && per_gnt_i) begin
        req = per_req_data_o;
        assert (req.wen_n == exp_wen_n && req.add == exp_add)
          else report_error($sformatf("Request add %0h wen_n %0b, expected %0h %0b",
                                      req.add, req.wen_n, exp_add, exp_wen_n));
        if (!req.wen_n) begin
          assert (req.wdata == exp_wdata && req.be == exp_be)
            else report_error($sformatf("Write data %0h be %0h, expected %0h %0h",
                                        req.wdata, req.be, exp_wdata, exp_be));
        end
        resp = '0;
        if (req.add >= 32'h400) begin
          resp.opc = 1'b1;
        end else if (req.wen_n) begin
          resp.rdata = per_mem[req.add[9:2]];
        end else begin
          for (idx = 0; idx < 4; idx++) begin
            if (req.be[idx]) begin
              per_mem[req.add[9:2]][8*idx +: 8] = req.wdata[8*idx +: 8];
            end
          end
        end
        // Response 1 to 3 cycles after the grant
        delay = 1 + $unsigned($random(seed)) % 3;
        #1;
        per_gnt_i = 1'b0;
        for (idx = 1; idx < delay; idx++) begin
          @(posedge clk_i);
          #1;
        end
        per_resp_i    = resp;
        per_r_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        per_r_valid_i = 1'b0;
      end else if (per_req_o) begin
        // Grant after 0 to 2 extra cycles
        delay = $unsigned($random(seed)) % 3;
        for (idx = 0; idx < delay; idx++) begin
          @(posedge clk_i);
        end
        #1;
        per_gnt_i = 1'b1;
      end
    end
  end

  // ****************************************
  // AXI master
  // ****************************************

  task automatic send_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, input logic [2:0] id,
                            input logic [5:0] user);
    int waited;
    int lane;
    int b;
    aw_i.id    = id;
    aw_i.addr  = addr;
    aw_i.user  = user;
    w_i.data   = data;
    w_i.strb   = strb;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    waited     = 0;
    while (1) begin
      @(posedge clk_i);
      if (aw_ready_o && w_ready_o) break;
      waited++;
      if (waited >= max_wait) begin
        report_timeout("AW/W acceptance");
        break;
      end
    end
    #1;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    // Merge the strobed bytes of the addressed lane
    lane = addr[2];
    if (addr < 32'h400) begin
      for (b = 0; b < 4; b++) begin
        if (strb[4*lane + b]) begin
          shadow_mem[addr[9:2]][8*b +: 8] = data[32*lane + 8*b +: 8];
        end
      end
    end
  endtask

  task automatic send_ar(input logic [31:0] addr, input logic [2:0] id,
                         input logic [5:0] user);
    int waited;
    ar_i.id    = id;
    ar_i.addr  = addr;
    ar_i.user  = user;
    ar_valid_i = 1'b1;
    waited     = 0;
    while (1) begin
      @(posedge clk_i);
      if (ar_ready_o) break;
      waited++;
      if (waited >= max_wait) begin
        report_timeout("AR acceptance");
        break;
      end
    end
    #1;
    ar_valid_i = 1'b0;
  endtask

  // Ready held low for a random number of cycles after valid
  task automatic collect_b(input logic [31:0] addr, input logic [2:0] id,
                           input logic [5:0] user);
    int waited;
    int hold;
    hold   = $unsigned($random(seed)) % 4;
    waited = 0;
    while (1) begin
      @(posedge clk_i);
      if (b_valid_o && b_ready_i) begin
        assert (b_o.id == id && b_o.user == user)
          else report_error($sformatf("B id %0h user %0h, expected %0h %0h",
                                      b_o.id, b_o.user, id, user));
        assert (b_o.resp == expected_resp(addr))
          else report_error($sformatf("B resp %0b at addr %0h", b_o.resp, addr));
        break;
      end
      waited++;
      if (waited >= max_wait) begin
        report_timeout("B handshake");
        break;
      end
      if (b_valid_o) begin
        if (hold == 0) begin
          #1;
          b_ready_i = 1'b1;
        end else begin
          hold--;
        end
      end
    end
    #1;
    b_ready_i = 1'b0;
  endtask

  task automatic collect_r(input logic [31:0] addr, input logic [2:0] id,
                           input logic [5:0] user);
    int          waited;
    int          hold;
    logic [31:0] word;
    logic [63:0] exp_data;
    // Read half lands in its lane with the other half zero
    word     = shadow_mem[addr[9:2]];
    exp_data = addr[2] ? {word, 32'h0} : {32'h0, word};
    hold     = $unsigned($random(seed)) % 4;
    waited   = 0;
    while (1) begin
      @(posedge clk_i);
      if (r_valid_o && r_ready_i) begin
        assert (r_o.id == id && r_o.user == user && r_o.last)
          else report_error($sformatf("R id %0h user %0h last %0b, expected %0h %0h 1",
                                      r_o.id, r_o.user, r_o.last, id, user));
        assert (r_o.resp == expected_resp(addr))
          else report_error($sformatf("R resp %0b at addr %0h", r_o.resp, addr));
        if (addr < 32'h400) begin
          assert (r_o.data == exp_data)
            else report_error($sformatf("R data %0h at addr %0h, expected %0h",
                                        r_o.data, addr, exp_data));
        end
        break;
      end
      waited++;
      if (waited >= max_wait) begin
        report_timeout("R handshake");
        break;
      end
      if (r_valid_o) begin
        if (hold == 0) begin
          #1;
          r_ready_i = 1'b1;
        end else begin
          hold--;
        end
      end
    end
    #1;
    r_ready_i = 1'b0;
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb, input logic [2:0] id,
                          input logic [5:0] user);
    send_write(addr, data, strb, id, user);
    collect_b(addr, id, user);
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [2:0] id,
                         input logic [5:0] user);
    send_ar(addr, id, user);
    collect_r(addr, id, user);
  endtask

  // Read goes first when AR and AW/W are raised together
  task automatic read_beside_write(input logic [31:0] raddr, input logic [31:0] waddr,
                                   input logic [63:0] data);
    aw_i.id    = 3'd5;
    aw_i.addr  = waddr;
    aw_i.user  = 6'h15;
    w_i.data   = data;
    w_i.strb   = 8'hff;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    send_ar(raddr, 3'd6, 6'h26);
    collect_r(raddr, 3'd6, 6'h26);
    do_write(waddr, data, 8'hff, 3'd5, 6'h15);
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin : main_sequence
    int          i;
    logic [31:0] rnd;
    logic [31:0] addr;
    rst_ni        = 1'b0;
    aw_valid_i    = 1'b0;
    w_valid_i     = 1'b0;
    ar_valid_i    = 1'b0;
    r_ready_i     = 1'b0;
    b_ready_i     = 1'b0;
    aw_i          = '0;
    w_i           = '0;
    ar_i          = '0;
    error_count   = 0;
    timeout_count = 0;
    for (i = 0; i < 256; i++) begin
      shadow_mem[i] = fill_word(i[7:0]);
    end
    repeat (5) @(posedge clk_i);
    assert (!per_req_o && !r_valid_o && !b_valid_o)
      else report_error("Request or response valid high in reset");
    assert (aw_ready_o && w_ready_o && ar_ready_o)
      else report_error("AXI readies not high while idle");
    #1;
    rst_ni = 1'b1;

    // Partial strobes in each lane and a read back of each
    do_write(32'h10, 64'h1111_2222_3333_4444, 8'h05, 3'd1, 6'h11);
    do_read(32'h10, 3'd2, 6'h22);
    do_write(32'h14, 64'hdead_beef_0bad_f00d, 8'ha0, 3'd3, 6'h33);
    do_read(32'h14, 3'd4, 6'h3f);

    // Out of range gives SLVERR
    do_write(32'h400, 64'h0, 8'hff, 3'd7, 6'h01);
    do_read(32'h404, 3'd0, 6'h02);

    read_beside_write(32'h20, 32'h24, 64'hcafe_f00d_1234_5678);
    do_read(32'h24, 3'd1, 6'h04);

    // Random reads and writes that also reach the SLVERR region
    for (i = 0; i < 60; i++) begin
      rnd  = $random(seed);
      addr = rnd & 32'h4fc;
      rnd  = $random(seed);
      if (rnd[0]) begin
        do_write(addr, {$random(seed), $random(seed)}, rnd[15:8], rnd[3:1], rnd[21:16]);
      end else begin
        do_read(addr, rnd[3:1], rnd[21:16]);
      end
    end

    repeat (3) @(posedge clk_i);
    $display("Run complete: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
